// File: rtl/fm_pkg.sv
// shared register map, sizes and bundles for the FM register front end
// compile before any other RTL file
package fm_pkg;

	// global registers, handled inside the control module
	localparam logic [7:0] REG_LFO     = 8'h22;
	localparam logic [7:0] REG_CLKA1   = 8'h24;
	localparam logic [7:0] REG_CLKA2   = 8'h25;
	localparam logic [7:0] REG_CLKB    = 8'h26;
	localparam logic [7:0] REG_TIMER   = 8'h27;
	localparam logic [7:0] REG_KON     = 8'h28;
	localparam logic [7:0] REG_PCM     = 8'h2A;
	localparam logic [7:0] REG_PCM_EN  = 8'h2B;
	localparam logic [7:0] REG_DACTEST = 8'h2C;
	localparam logic [7:0] REG_CLK_N6  = 8'h2D;
	localparam logic [7:0] REG_CLK_N3  = 8'h2E;
	localparam logic [7:0] REG_CLK_N2  = 8'h2F;

	// parameter register groups
	localparam logic [7:0] REG_DT_MUL   = 8'h30;
	localparam logic [7:0] REG_TL       = 8'h40;
	localparam logic [7:0] REG_KS_AR    = 8'h50;
	localparam logic [7:0] REG_FNUM_LO  = 8'hA0;
	localparam logic [7:0] REG_FNUM_HI  = 8'hA4;
	localparam logic [7:0] REG_FB_ALG   = 8'hB0;

	localparam int NUM_CH   = 6;
	localparam int NUM_OP   = 4;
	localparam int NUM_SLOT = 24;

	// clk_en ticks per timer B count
	localparam int TIMER_B_PRESCALE = 16;

	// prescaler selection
	localparam logic [1:0] DIV_N6 = 2'd0;
	localparam logic [1:0] DIV_N3 = 2'd1;
	localparam logic [1:0] DIV_N2 = 2'd2;

	// kind of a parameter write
	localparam logic [2:0] KIND_DT_MUL  = 3'd0;
	localparam logic [2:0] KIND_TL      = 3'd1;
	localparam logic [2:0] KIND_KS_AR   = 3'd2;
	localparam logic [2:0] KIND_FNUM_LO = 3'd3;
	localparam logic [2:0] KIND_FNUM_HI = 3'd4;
	localparam logic [2:0] KIND_FB_ALG  = 3'd5;
	localparam logic [2:0] KIND_KEYON   = 3'd6;

	typedef struct packed {
		logic       lfo_en;
		logic [2:0] lfo_freq;
		logic [8:0] pcm;
		logic       pcm_en;
	} glb_cfg_t;

	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       irq_en_a;
		logic       irq_en_b;
		logic       clr_a;
		logic       clr_b;
	} tmr_ctrl_t;

	typedef struct packed {
		logic       wr;
		logic [2:0] kind;
		logic [2:0] ch;
		logic [1:0] op;
		logic [7:0] data;
	} chan_wr_t;

	typedef struct packed {
		logic [2:0]  ch;
		logic [1:0]  op;
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [2:0]  dt;
		logic [3:0]  mul;
		logic [6:0]  tl;
		logic [1:0]  ks;
		logic [4:0]  ar;
		logic        keyon;
	} slot_param_t;

endpackage

// File: rtl/fm_mmr.sv
// host register port: write edge detection, register decode and busy
// global settings are held here, parameter writes leave as chan_wr strobes
`timescale 1ns/1ps

module fm_mmr (
	input  logic              clk,
	input  logic              rst,
	input  logic              clk_en,
	input  logic [7:0]        din,
	input  logic [1:0]        addr,
	input  logic              write,
	input  logic              wr_done,
	output logic              busy,
	output fm_pkg::glb_cfg_t  glb,
	output fm_pkg::tmr_ctrl_t tmr,
	output logic [1:0]        div_sel,
	output fm_pkg::chan_wr_t  chan_wr
);

	logic       write_q;
	logic       wr_edge;
	logic [7:0] sel_reg;
	logic       bank;
	logic       par_hit;
	logic [2:0] par_kind;
	logic [2:0] par_ch;
	logic [1:0] par_op;

	assign wr_edge = write & ~write_q;

	// upper bank maps channels 0..2 onto 3..5
	assign par_ch = {1'b0, sel_reg[1:0]} + (bank ? 3'd3 : 3'd0);

	// register bits [3:2] come in slot order S1, S3, S2, S4
	assign par_op = {sel_reg[2], sel_reg[3]};

	always_comb begin
		par_hit  = 1'b1;
		par_kind = fm_pkg::KIND_DT_MUL;
		if (sel_reg[1:0] == 2'b11) begin
			// no fourth channel in a bank
			par_hit = 1'b0;
		end else if (sel_reg[7:4] == fm_pkg::REG_DT_MUL[7:4]) begin
			par_kind = fm_pkg::KIND_DT_MUL;
		end else if (sel_reg[7:4] == fm_pkg::REG_TL[7:4]) begin
			par_kind = fm_pkg::KIND_TL;
		end else if (sel_reg[7:4] == fm_pkg::REG_KS_AR[7:4]) begin
			par_kind = fm_pkg::KIND_KS_AR;
		end else if (sel_reg[7:2] == fm_pkg::REG_FNUM_LO[7:2]) begin
			par_kind = fm_pkg::KIND_FNUM_LO;
		end else if (sel_reg[7:2] == fm_pkg::REG_FNUM_HI[7:2]) begin
			par_kind = fm_pkg::KIND_FNUM_HI;
		end else if (sel_reg[7:2] == fm_pkg::REG_FB_ALG[7:2]) begin
			par_kind = fm_pkg::KIND_FB_ALG;
		end else begin
			par_hit = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			write_q    <= 1'b0;
			sel_reg    <= 8'h00;
			bank       <= 1'b0;
			busy       <= 1'b0;
			glb        <= '0;
			tmr        <= '0;
			div_sel    <= fm_pkg::DIV_N6;
			chan_wr.wr <= 1'b0;
		end else begin
			write_q    <= write;
			chan_wr.wr <= 1'b0;

			if (wr_done)
				busy <= 1'b0;

			// flag clears only last until the next tick
			if (clk_en) begin
				tmr.clr_a <= 1'b0;
				tmr.clr_b <= 1'b0;
			end

			if (wr_edge && !addr[0]) begin
				sel_reg <= din;
				bank    <= addr[1];
			end else if (wr_edge && !busy) begin
				if (sel_reg < fm_pkg::REG_DT_MUL) begin
					case (sel_reg)
						fm_pkg::REG_LFO: begin
							glb.lfo_en   <= din[3];
							glb.lfo_freq <= din[2:0];
						end
						fm_pkg::REG_CLKA1:   tmr.value_a[9:2] <= din;
						fm_pkg::REG_CLKA2:   tmr.value_a[1:0] <= din[1:0];
						fm_pkg::REG_CLKB:    tmr.value_b <= din;
						fm_pkg::REG_TIMER: begin
							tmr.load_a   <= din[0];
							tmr.load_b   <= din[1];
							tmr.irq_en_a <= din[2];
							tmr.irq_en_b <= din[3];
							tmr.clr_a    <= din[4];
							tmr.clr_b    <= din[5];
						end
						fm_pkg::REG_KON: begin
							// channel in din[2:0], operator keys in din[7:4]
							chan_wr.wr   <= 1'b1;
							chan_wr.kind <= fm_pkg::KIND_KEYON;
							chan_wr.ch   <= din[2:0];
							chan_wr.op   <= 2'd0;
							chan_wr.data <= din;
							busy         <= 1'b1;
						end
						fm_pkg::REG_PCM:     glb.pcm[8:1] <= din;
						fm_pkg::REG_DACTEST: glb.pcm[0] <= din[3];
						fm_pkg::REG_PCM_EN:  glb.pcm_en <= din[7];
						fm_pkg::REG_CLK_N6:  div_sel <= fm_pkg::DIV_N6;
						fm_pkg::REG_CLK_N3:  div_sel <= fm_pkg::DIV_N3;
						fm_pkg::REG_CLK_N2:  div_sel <= fm_pkg::DIV_N2;
						default: ;
					endcase
				end else if (par_hit) begin
					chan_wr.wr   <= 1'b1;
					chan_wr.kind <= par_kind;
					chan_wr.ch   <= par_ch;
					chan_wr.op   <= par_op;
					chan_wr.data <= din;
					busy         <= 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/fm_cen_div.sv
// clock enable prescaler, divides the host cen by 6, 3 or 2
`timescale 1ns/1ps

module fm_cen_div (
	input  logic       clk,
	input  logic       rst,
	input  logic       cen,
	input  logic [1:0] div_sel,
	output logic       clk_en
);

	logic [2:0] cnt;
	logic [2:0] lim;

	always_comb begin
		case (div_sel)
			fm_pkg::DIV_N3: lim = 3'd2;
			fm_pkg::DIV_N2: lim = 3'd1;
			default:        lim = 3'd5;
		endcase
	end

	// >= so a smaller divider takes over without a long wrap
	assign clk_en = cen & (cnt >= lim);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= 3'd0;
		end else if (cen) begin
			if (cnt >= lim)
				cnt <= 3'd0;
			else
				cnt <= cnt + 3'd1;
		end
	end

endmodule

// File: rtl/fm_timers.sv
// timer A (10 bit) and timer B (8 bit) with sticky flags and interrupt
// both count on clk_en, timer B through a prescaler
`timescale 1ns/1ps

module fm_timers (
	input  logic              clk,
	input  logic              rst,
	input  logic              clk_en,
	input  fm_pkg::tmr_ctrl_t tmr,
	output logic              flag_a,
	output logic              flag_b,
	output logic              irq
);

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [$clog2(fm_pkg::TIMER_B_PRESCALE)-1:0] pre_b;
	logic       tick_b;

	assign tick_b = clk_en && int'(pre_b) == fm_pkg::TIMER_B_PRESCALE - 1;
	assign irq    = flag_a | flag_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a  <= 10'd0;
			flag_a <= 1'b0;
		end else begin
			if (!tmr.load_a) begin
				// stopped counter follows the reload value
				cnt_a <= tmr.value_a;
			end else if (clk_en) begin
				if (cnt_a == 10'h3ff) begin
					cnt_a <= tmr.value_a;
					if (tmr.irq_en_a)
						flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 10'd1;
				end
			end
			if (tmr.clr_a || !tmr.irq_en_a)
				flag_a <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_b  <= 8'd0;
			pre_b  <= '0;
			flag_b <= 1'b0;
		end else begin
			if (!tmr.load_b) begin
				cnt_b <= tmr.value_b;
				pre_b <= '0;
			end else if (clk_en) begin
				pre_b <= pre_b + 1'b1;
				if (tick_b) begin
					if (cnt_b == 8'hff) begin
						cnt_b <= tmr.value_b;
						if (tmr.irq_en_b)
							flag_b <= 1'b1;
					end else begin
						cnt_b <= cnt_b + 8'd1;
					end
				end
			end
			if (tmr.clr_b || !tmr.irq_en_b)
				flag_b <= 1'b0;
		end
	end

endmodule

// File: rtl/fm_chan_regs.sv
// channel and operator parameter store with key-on bits
// writes land on clk_en, the output scans one slot per clk_en
`timescale 1ns/1ps

module fm_chan_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                clk_en,
	input  fm_pkg::chan_wr_t    chan_wr,
	output logic                wr_done,
	output fm_pkg::slot_param_t slot
);

	// per channel
	logic [10:0] fnum     [fm_pkg::NUM_CH];
	logic [2:0]  block    [fm_pkg::NUM_CH];
	logic [5:0]  fhi_latch[fm_pkg::NUM_CH];
	logic [2:0]  fb       [fm_pkg::NUM_CH];
	logic [2:0]  alg      [fm_pkg::NUM_CH];

	// per slot, indexed op * NUM_CH + ch
	logic [2:0] dt [fm_pkg::NUM_SLOT];
	logic [3:0] mul[fm_pkg::NUM_SLOT];
	logic [6:0] tl [fm_pkg::NUM_SLOT];
	logic [1:0] ks [fm_pkg::NUM_SLOT];
	logic [4:0] ar [fm_pkg::NUM_SLOT];
	logic [fm_pkg::NUM_SLOT-1:0] keyon;

	fm_pkg::chan_wr_t pend;
	fm_pkg::chan_wr_t cur;
	logic       pend_vld;
	logic [4:0] wr_slot;
	logic [2:0] scan_ch;
	logic [1:0] scan_op;
	logic [4:0] scan_slot;

	// a strobe on a clk_en cycle is applied at once
	assign cur       = chan_wr.wr ? chan_wr : pend;
	assign wr_done   = clk_en & (chan_wr.wr | pend_vld);
	assign wr_slot   = 5'(cur.op) * 5'(fm_pkg::NUM_CH) + 5'(cur.ch);
	assign scan_slot = 5'(scan_op) * 5'(fm_pkg::NUM_CH) + 5'(scan_ch);

	always_ff @(posedge clk) begin
		if (rst) begin
			pend_vld <= 1'b0;
			keyon    <= '0;
			scan_ch  <= 3'd0;
			scan_op  <= 2'd0;
		end else begin
			if (chan_wr.wr && !clk_en) begin
				pend     <= chan_wr;
				pend_vld <= 1'b1;
			end
			if (clk_en) begin
				pend_vld <= 1'b0;
				if (scan_ch == 3'(fm_pkg::NUM_CH - 1)) begin
					scan_ch <= 3'd0;
					scan_op <= scan_op + 2'd1;
				end else begin
					scan_ch <= scan_ch + 3'd1;
				end
			end
			if (wr_done && cur.ch < fm_pkg::NUM_CH) begin
				case (cur.kind)
					fm_pkg::KIND_DT_MUL: begin
						dt[wr_slot]  <= cur.data[6:4];
						mul[wr_slot] <= cur.data[3:0];
					end
					fm_pkg::KIND_TL: tl[wr_slot] <= cur.data[6:0];
					fm_pkg::KIND_KS_AR: begin
						ks[wr_slot] <= cur.data[7:6];
						ar[wr_slot] <= cur.data[4:0];
					end
					// high byte waits in the latch for the low byte
					fm_pkg::KIND_FNUM_HI: fhi_latch[cur.ch] <= cur.data[5:0];
					fm_pkg::KIND_FNUM_LO: begin
						fnum[cur.ch]  <= {fhi_latch[cur.ch][2:0], cur.data};
						block[cur.ch] <= fhi_latch[cur.ch][5:3];
					end
					fm_pkg::KIND_FB_ALG: begin
						fb[cur.ch]  <= cur.data[5:3];
						alg[cur.ch] <= cur.data[2:0];
					end
					fm_pkg::KIND_KEYON: begin
						for (int op = 0; op < fm_pkg::NUM_OP; op++)
							keyon[op * fm_pkg::NUM_CH + cur.ch] <= cur.data[4 + op];
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		slot.ch    = scan_ch;
		slot.op    = scan_op;
		slot.fnum  = fnum[scan_ch];
		slot.block = block[scan_ch];
		slot.fb    = fb[scan_ch];
		slot.alg   = alg[scan_ch];
		slot.dt    = dt[scan_slot];
		slot.mul   = mul[scan_slot];
		slot.tl    = tl[scan_slot];
		slot.ks    = ks[scan_slot];
		slot.ar    = ar[scan_slot];
		slot.keyon = keyon[scan_slot];
	end

endmodule

// File: rtl/fm_top.sv
// FM register front end, top level
// host byte port in; global settings, scanned slot parameters and status out
`timescale 1ns/1ps

module fm_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                cen,
	input  logic [7:0]          din,
	input  logic [1:0]          addr,
	input  logic                write,
	output logic                busy,
	output logic [7:0]          status,
	output logic                irq,
	output fm_pkg::glb_cfg_t    glb,
	output fm_pkg::slot_param_t slot,
	output logic                clk_en
);

	fm_pkg::tmr_ctrl_t tmr;
	fm_pkg::chan_wr_t  chan_wr;
	logic [1:0]        div_sel;
	logic              wr_done;
	logic              flag_a;
	logic              flag_b;

	// busy in bit 7, timer flags in bits 1 and 0
	assign status = {busy, 5'b00000, flag_b, flag_a};

	fm_mmr u_mmr (
		.clk     (clk),
		.rst     (rst),
		.clk_en  (clk_en),
		.din     (din),
		.addr    (addr),
		.write   (write),
		.wr_done (wr_done),
		.busy    (busy),
		.glb     (glb),
		.tmr     (tmr),
		.div_sel (div_sel),
		.chan_wr (chan_wr)
	);

	fm_cen_div u_cen_div (
		.clk     (clk),
		.rst     (rst),
		.cen     (cen),
		.div_sel (div_sel),
		.clk_en  (clk_en)
	);

	fm_timers u_timers (
		.clk    (clk),
		.rst    (rst),
		.clk_en (clk_en),
		.tmr    (tmr),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq    (irq)
	);

	fm_chan_regs u_chan_regs (
		.clk     (clk),
		.rst     (rst),
		.clk_en  (clk_en),
		.chan_wr (chan_wr),
		.wr_done (wr_done),
		.slot    (slot)
	);

endmodule

// File: testbench/tb_fm_top.sv
// self-checking testbench for the FM register front end
// host port driven on the falling edge, results compared with a reference model
`timescale 1ns/1ps

module tb_fm_top;

	localparam int CLK_NS = 4;
	localparam int NUM_WRITES = 40 + 90 + 400 + 20;
	// two write pulses, a clk_en sync and a full busy period at divider 6
	localparam int WRITE_CYCLES = 18;
	localparam int EXTRA_CYCLES = 2000;
	localparam int TIMEOUT_NS = (NUM_WRITES * WRITE_CYCLES + EXTRA_CYCLES) * CLK_NS * 2;

	typedef enum int {K_NONE, K_DT_MUL, K_TL, K_KS_AR, K_FNUM_HI, K_FNUM_LO, K_FB_ALG,
		K_KEYON} wr_kind_e;

	logic                clk = 1'b0;
	logic                rst;
	logic                cen;
	logic [7:0]          din;
	logic [1:0]          addr;
	logic                write;
	logic                busy;
	logic [7:0]          status;
	logic                irq;
	fm_pkg::glb_cfg_t    glb;
	fm_pkg::slot_param_t slot;
	logic                clk_en;

	// reference model
	fm_pkg::slot_param_t m_slot [fm_pkg::NUM_CH][fm_pkg::NUM_OP];
	logic [5:0]          m_fhi [fm_pkg::NUM_CH];
	fm_pkg::glb_cfg_t    exp_glb;
	bit                  model_valid = 1'b0;
	int                  cur_div = 6;
	int                  errors = 0;
	int                  test_err = 0;
	int                  tests = 0;
	logic [7:0]          glb_reg [4] = '{fm_pkg::REG_LFO, fm_pkg::REG_PCM,
		fm_pkg::REG_DACTEST, fm_pkg::REG_PCM_EN};
	logic [7:0]          div_reg [3] = '{fm_pkg::REG_CLK_N2, fm_pkg::REG_CLK_N3,
		fm_pkg::REG_CLK_N6};
	int                  div_n [3] = '{2, 3, 6};

	always #(CLK_NS / 2) clk = ~clk;

	fm_top DUT (
		.clk    (clk),
		.rst    (rst),
		.cen    (cen),
		.din    (din),
		.addr   (addr),
		.write  (write),
		.busy   (busy),
		.status (status),
		.irq    (irq),
		.glb    (glb),
		.slot   (slot),
		.clk_en (clk_en)
	);

	assert property (@(posedge clk) disable iff (rst) status[7:2] == {busy, 5'd0})
		else begin
			errors++;
			$display("Error: status[7:2] expected %h actual %h", {busy, 5'd0}, status[7:2]);
		end

	assert property (@(posedge clk) disable iff (rst) irq == (status[0] | status[1]))
		else begin
			errors++;
			$display("Error: irq expected %h actual %h", status[0] | status[1], irq);
		end

	// a pending parameter write keeps busy high, so only idle cycles are compared
	always @(negedge clk)
		if (model_valid && !busy)
			check_val("slot", m_slot[slot.ch][slot.op], slot);

	task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
		assert (got === exp) else begin
			errors++;
			$display("Error: %s expected %0h actual %0h", name, exp, got);
		end
	endtask

	task automatic check_true(bit ok, string what);
		assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic pulse_write(logic [1:0] a, logic [7:0] d);
		addr  = a;
		din   = d;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0;
		@(negedge clk);
	endtask

	task automatic apply_model(wr_kind_e kind, int c, int o, logic [7:0] d);
		case (kind)
			K_DT_MUL: m_slot[c][o].dt = d[6:4];
			K_TL:     m_slot[c][o].tl = d[6:0];
			K_KS_AR:  m_slot[c][o].ks = d[7:6];
			K_FNUM_HI: m_fhi[c] = d[5:0];
			default: ;
		endcase
		if (kind == K_DT_MUL)
			m_slot[c][o].mul = d[3:0];
		if (kind == K_KS_AR)
			m_slot[c][o].ar = d[4:0];
		// channel fields are shared by all four operators
		for (int i = 0; i < fm_pkg::NUM_OP; i++) begin
			if (kind == K_FNUM_LO) begin
				m_slot[c][i].fnum  = {m_fhi[c][2:0], d};
				m_slot[c][i].block = m_fhi[c][5:3];
			end
			if (kind == K_FB_ALG) begin
				m_slot[c][i].fb  = d[5:3];
				m_slot[c][i].alg = d[2:0];
			end
			if (kind == K_KEYON)
				m_slot[c][i].keyon = d[4 + i];
		end
	endtask

	task automatic host_write(logic [7:0] rnum, bit bank, logic [7:0] d, wr_kind_e kind,
		int c, int o, bit twice);
		time t_edge;
		bit  seen_busy;
		pulse_write({bank, 1'b0}, rnum);
		// start right after a clk_en so busy lasts a whole divider period
		if (twice)
			while (!clk_en)
				@(negedge clk);
		addr  = {bank, 1'b1};
		din   = d;
		write = 1'b1;
		@(negedge clk);
		t_edge    = $time;
		seen_busy = busy;
		apply_model(kind, c, o, d);
		write = 1'b0;
		@(negedge clk);
		if (twice) begin
			check_true(busy, "busy fell before the second data write");
			pulse_write({bank, 1'b1}, ~d);
		end
		while (busy && $time - t_edge <= 2 * cur_div * CLK_NS)
			@(negedge clk);
		check_true(seen_busy == (kind != K_NONE), "busy level after a data write is wrong");
		check_true($time - t_edge <= cur_div * CLK_NS,
			"busy stayed high longer than one divider period");
	endtask

	task automatic write_param(wr_kind_e kind, int c, int o, logic [7:0] d, bit bad, bit twice);
		logic [7:0] base;
		logic [1:0] obits;
		// register bits [3:2] run in slot order S1, S3, S2, S4
		obits = {o[0], o[1]};
		case (kind)
			K_DT_MUL:  base = fm_pkg::REG_DT_MUL | {4'd0, obits, 2'd0};
			K_TL:      base = fm_pkg::REG_TL | {4'd0, obits, 2'd0};
			K_KS_AR:   base = fm_pkg::REG_KS_AR | {4'd0, obits, 2'd0};
			K_FNUM_LO: base = fm_pkg::REG_FNUM_LO;
			K_FNUM_HI: base = fm_pkg::REG_FNUM_HI;
			default:   base = fm_pkg::REG_FB_ALG;
		endcase
		if (kind == K_KEYON)
			host_write(fm_pkg::REG_KON, 1'b0, {d[7:4], 1'b0, 3'(c)}, K_KEYON, c, o, twice);
		else
			host_write(base | (bad ? 8'd3 : 8'(c % 3)), c >= 3, d, bad ? K_NONE : kind,
				c, o, twice);
	endtask

	task automatic random_param();
		int         r;
		int         c;
		int         o;
		logic [7:0] d;
		r = $urandom % 8;
		c = $urandom % fm_pkg::NUM_CH;
		o = $urandom % fm_pkg::NUM_OP;
		d = 8'($urandom);
		if (r == 7)
			// low bits of 3 select no channel
			write_param(wr_kind_e'(1 + $urandom % 6), c, o, d, 1'b1, 1'b0);
		else if (r == 6)
			write_param(K_FNUM_HI, c, o, d, 1'b0, 1'b0);
		else if (r == 3) begin
			write_param(K_FNUM_HI, c, o, d, 1'b0, 1'b0);
			write_param(K_FNUM_LO, c, o, 8'($urandom), 1'b0, 1'b0);
		end else
			write_param(wr_kind_e'(r == 5 ? 7 : r + 1 + (r == 4)), c, o, d, 1'b0, 1'b0);
	endtask

	task automatic wait_flag(int bit_i, int max_ticks, string name);
		int ticks;
		ticks = 0;
		while (!status[bit_i] && ticks <= max_ticks) begin
			if (clk_en)
				ticks++;
			@(negedge clk);
		end
		check_true(status[bit_i] && irq, {name, " did not rise in time"});
	endtask

	task automatic check_spacing(int n);
		int idx;
		int cnt;
		@(negedge clk);
		while (!clk_en)
			@(negedge clk);
		repeat (3) begin
			idx = int'(slot.op) * fm_pkg::NUM_CH + int'(slot.ch);
			cnt = 0;
			do begin
				@(negedge clk);
				cnt++;
			end while (!clk_en && cnt < 8);
			check_val("clk_en spacing", n, cnt);
			check_val("slot index", (idx + 1) % fm_pkg::NUM_SLOT,
				int'(slot.op) * fm_pkg::NUM_CH + int'(slot.ch));
		end
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int         r;
		logic [7:0] d;
		void'($urandom(32'h9cf6_c61a));
		rst   = 1'b1;
		cen   = 1'b1;
		din   = 8'h00;
		addr  = 2'd0;
		write = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_val("busy", 0, busy);
		check_val("irq", 0, irq);
		check_val("status", 0, status);
		check_val("glb", 0, glb);
		repeat (fm_pkg::NUM_SLOT * cur_div) begin
			@(negedge clk);
			check_val("slot.keyon", 0, slot.keyon);
		end
		finish_test("reset");

		exp_glb = '0;
		repeat (40) begin
			r = $urandom % 4;
			d = 8'($urandom);
			host_write(glb_reg[r], 1'b0, d, K_NONE, 0, 0, 1'b0);
			case (r)
				0: exp_glb.lfo_freq = d[2:0];
				1: exp_glb.pcm[8:1] = d;
				2: exp_glb.pcm[0] = d[3];
				default: exp_glb.pcm_en = d[7];
			endcase
			if (r == 0)
				exp_glb.lfo_en = d[3];
			@(negedge clk);
			check_val("glb", exp_glb, glb);
		end
		finish_test("global");

		// every stored field gets a known value first
		for (int c = 0; c < fm_pkg::NUM_CH; c++) begin
			for (int o = 0; o < fm_pkg::NUM_OP; o++) begin
				m_slot[c][o].ch    = 3'(c);
				m_slot[c][o].op    = 2'(o);
				m_slot[c][o].keyon = 1'b0;
				write_param(K_DT_MUL, c, o, 8'($urandom), 1'b0, 1'b0);
				write_param(K_TL, c, o, 8'($urandom), 1'b0, 1'b0);
				write_param(K_KS_AR, c, o, 8'($urandom), 1'b0, 1'b0);
			end
			write_param(K_FNUM_HI, c, 0, 8'($urandom), 1'b0, 1'b0);
			write_param(K_FNUM_LO, c, 0, 8'($urandom), 1'b0, 1'b0);
			write_param(K_FB_ALG, c, 0, 8'($urandom), 1'b0, 1'b0);
		end
		model_valid = 1'b1;
		repeat (200) random_param();
		finish_test("params");

		// the second data write lands while busy is high and must be dropped
		write_param(K_TL, 4, 2, 8'h5a, 1'b0, 1'b1);
		repeat (fm_pkg::NUM_SLOT * cur_div) @(negedge clk);
		finish_test("busy");

		host_write(fm_pkg::REG_CLKA1, 1'b0, 8'(1020 >> 2), K_NONE, 0, 0, 1'b0);
		host_write(fm_pkg::REG_CLKA2, 1'b0, 8'(1020 & 3), K_NONE, 0, 0, 1'b0);
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h05, K_NONE, 0, 0, 1'b0);
		wait_flag(0, 4, "flag_a");
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h15, K_NONE, 0, 0, 1'b0);
		check_true(!status[0] && !irq, "flag_a did not clear after clr_a");
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h00, K_NONE, 0, 0, 1'b0);
		host_write(fm_pkg::REG_CLKB, 1'b0, 8'd254, K_NONE, 0, 0, 1'b0);
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h0a, K_NONE, 0, 0, 1'b0);
		wait_flag(1, 2 * fm_pkg::TIMER_B_PRESCALE, "flag_b");
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h00, K_NONE, 0, 0, 1'b0);
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h03, K_NONE, 0, 0, 1'b0);
		repeat (40 * cur_div) begin
			@(negedge clk);
			check_true(!irq, "irq rose with both interrupt enables off");
		end
		host_write(fm_pkg::REG_TIMER, 1'b0, 8'h00, K_NONE, 0, 0, 1'b0);
		finish_test("timers");

		for (int i = 0; i < 3; i++) begin
			host_write(div_reg[i], 1'b0, 8'($urandom), K_NONE, 0, 0, 1'b0);
			cur_div = div_n[i];
			check_spacing(cur_div);
			random_param();
		end
		repeat (fm_pkg::NUM_SLOT * cur_div) @(negedge clk);
		finish_test("prescaler");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: fm_regs.f
rtl/fm_pkg.sv
rtl/fm_mmr.sv
rtl/fm_cen_div.sv
rtl/fm_timers.sv
rtl/fm_chan_regs.sv
rtl/fm_top.sv
testbench/tb_fm_top.sv
